/* common/lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// block geometry, shared by both caches and the block port
`define LC3B_BLOCK_BYTES 16
`define LC3B_CACHE_SETS 8

// address split, tag | index | offset
`define LC3B_OFFSET_BITS 4
`define LC3B_INDEX_BITS 3
`define LC3B_TAG_BITS 9

`endif

/* common/lc3b_types.sv */
`include "lc3b_settings.svh"

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [8*`LC3B_BLOCK_BYTES-1:0] lc3b_c_block;
	typedef logic [1:0] lc3b_mem_wmask;

	typedef logic [`LC3B_TAG_BITS-1:0] lc3b_cache_tag;
	typedef logic [`LC3B_INDEX_BITS-1:0] lc3b_cache_index;

	// word side request, held until mem_resp
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_word wdata;
		lc3b_mem_wmask byte_enable;
	} lc3b_mem_req;

	// block side request, address is block aligned
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_c_block wdata;
	} lc3b_pmem_req;

	typedef enum logic [1:0] {
		idle_check,
		write_back,
		fill
	} lc3b_cache_state;

endpackage : lc3b_types

/* cache/cache.sv */
`timescale 1ns/100ps
`include "lc3b_settings.svh"

module cache (
	input logic clk,
	input logic rst_n,

	input lc3b_types::lc3b_mem_req mem_req,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,

	output lc3b_types::lc3b_pmem_req pmem_req,
	input lc3b_types::lc3b_c_block pmem_rdata,
	input logic pmem_resp
);
	import lc3b_types::*;

	localparam int words_per_block = `LC3B_BLOCK_BYTES / 2;
	localparam int word_sel_bits = $clog2(words_per_block);
	localparam int word_bits = $bits(lc3b_word);

	lc3b_c_block data_array [`LC3B_CACHE_SETS];
	lc3b_cache_tag tag_array [`LC3B_CACHE_SETS];
	logic [`LC3B_CACHE_SETS-1:0] valid;
	logic [`LC3B_CACHE_SETS-1:0] dirty;

	lc3b_cache_state state;

	lc3b_cache_tag req_tag;
	lc3b_cache_index req_index;
	logic [word_sel_bits-1:0] word_sel;
	logic access;
	logic hit;
	logic fill_done;
	logic finish;
	logic line_load;
	lc3b_c_block line_in;
	lc3b_c_block line_merged;
	lc3b_word word_in;

	assign req_tag = mem_req.address[15 -: `LC3B_TAG_BITS];
	assign req_index = mem_req.address[`LC3B_OFFSET_BITS +: `LC3B_INDEX_BITS];
	assign word_sel = mem_req.address[word_sel_bits:1];

	// request still open, the resp cycle itself is not served twice
	assign access = (mem_req.read || mem_req.write) && !mem_resp;
	assign hit = valid[req_index] && (tag_array[req_index] == req_tag);

	assign fill_done = (state == fill) && pmem_resp;
	assign finish = access && (((state == idle_check) && hit) || fill_done);
	assign line_load = fill_done || (finish && mem_req.write);

	// during the last fill cycle the access works on the incoming block
	assign line_in = (state == fill) ? pmem_rdata : data_array[req_index];
	assign word_in = line_in[word_sel*word_bits +: word_bits];

	always_comb begin
		line_merged = line_in;
		if (mem_req.byte_enable[0])
			line_merged[word_sel*word_bits +: 8] = mem_req.wdata[7:0];
		if (mem_req.byte_enable[1])
			line_merged[word_sel*word_bits+8 +: 8] = mem_req.wdata[15:8];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle_check;
			valid <= '0;
			dirty <= '0;
			mem_resp <= 1'b0;
		end else begin
			mem_resp <= finish;
			case (state)
				idle_check: begin
					if (access && !hit) begin
						if (dirty[req_index])
							state <= write_back;
						else
							state <= fill;
					end
				end
				write_back: begin
					if (pmem_resp)
						state <= fill;
				end
				fill: begin
					if (pmem_resp) begin
						state <= idle_check;
						valid[req_index] <= 1'b1;
					end
				end
				default: state <= idle_check;
			endcase
			if (finish && mem_req.write)
				dirty[req_index] <= 1'b1;
			else if (fill_done)
				dirty[req_index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (finish)
			mem_rdata <= word_in;
		if (line_load) begin
			data_array[req_index] <= mem_req.write ? line_merged : line_in;
			tag_array[req_index] <= req_tag;
		end
	end

	always_comb begin
		pmem_req.read = (state == fill);
		pmem_req.write = (state == write_back);
		pmem_req.wdata = data_array[req_index];
		// victim goes back under its own tag
		if (state == write_back)
			pmem_req.address = {tag_array[req_index], req_index, {`LC3B_OFFSET_BITS{1'b0}}};
		else
			pmem_req.address = {req_tag, req_index, {`LC3B_OFFSET_BITS{1'b0}}};
	end

	resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> (mem_req.read || mem_req.write));

	pmem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_req.read || pmem_req.write) && !pmem_resp |=> $stable(pmem_req));

endmodule : cache

/* design/arbiter.sv */
`timescale 1ns/100ps

module arbiter (
	input logic clk,
	input logic rst_n,

	input lc3b_types::lc3b_pmem_req icache_pmem_req,
	input lc3b_types::lc3b_pmem_req dcache_pmem_req,

	output logic icache_pmem_resp,
	output logic dcache_pmem_resp,

	input logic pmem_resp,
	output lc3b_types::lc3b_word pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_c_block pmem_wdata
);
	import lc3b_types::*;

	typedef enum logic [1:0] {
		owner_none,
		owner_icache,
		owner_dcache
	} owner_t;

	owner_t owner;
	logic icache_wants;
	logic dcache_wants;
	lc3b_pmem_req granted;

	assign icache_wants = icache_pmem_req.read || icache_pmem_req.write;
	assign dcache_wants = dcache_pmem_req.read || dcache_pmem_req.write;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner <= owner_none;
		end else begin
			case (owner)
				// data side wins a tie
				owner_none: begin
					if (dcache_wants)
						owner <= owner_dcache;
					else if (icache_wants)
						owner <= owner_icache;
				end
				default: begin
					if (pmem_resp)
						owner <= owner_none;
				end
			endcase
		end
	end

	always_comb begin
		case (owner)
			owner_icache: granted = icache_pmem_req;
			owner_dcache: granted = dcache_pmem_req;
			default: granted = '0;
		endcase
	end

	assign pmem_address = granted.address;
	assign pmem_read = granted.read;
	assign pmem_write = granted.write;
	assign pmem_wdata = granted.wdata;

	assign icache_pmem_resp = pmem_resp && (owner == owner_icache);
	assign dcache_pmem_resp = pmem_resp && (owner == owner_dcache);

	one_direction: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write));

endmodule : arbiter

/* design/mp3_memory.sv */
`timescale 1ns/100ps

module mp3_memory (
	input logic clk,
	input logic rst_n,

	input lc3b_types::lc3b_mem_req icache_req,
	output lc3b_types::lc3b_word icache_rdata,
	output logic icache_resp,

	input lc3b_types::lc3b_mem_req dcache_req,
	output lc3b_types::lc3b_word dcache_rdata,
	output logic dcache_resp,

	input logic pmem_resp,
	input lc3b_types::lc3b_c_block pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_c_block pmem_wdata
);
	import lc3b_types::*;

	lc3b_mem_req icache_rd_req;
	lc3b_pmem_req icache_pmem_req;
	lc3b_pmem_req dcache_pmem_req;
	logic icache_pmem_resp;
	logic dcache_pmem_resp;

	// instruction side never writes
	assign icache_rd_req = '{
		address: icache_req.address,
		read: icache_req.read,
		write: 1'b0,
		wdata: icache_req.wdata,
		byte_enable: icache_req.byte_enable
	};

	cache i_cache (
		.clk,
		.rst_n,
		.mem_req(icache_rd_req),
		.mem_rdata(icache_rdata),
		.mem_resp(icache_resp),
		.pmem_req(icache_pmem_req),
		.pmem_rdata,
		.pmem_resp(icache_pmem_resp)
	);

	cache d_cache (
		.clk,
		.rst_n,
		.mem_req(dcache_req),
		.mem_rdata(dcache_rdata),
		.mem_resp(dcache_resp),
		.pmem_req(dcache_pmem_req),
		.pmem_rdata,
		.pmem_resp(dcache_pmem_resp)
	);

	arbiter arbiter (
		.clk,
		.rst_n,
		.icache_pmem_req,
		.dcache_pmem_req,
		.icache_pmem_resp,
		.dcache_pmem_resp,
		.pmem_resp,
		.pmem_address,
		.pmem_read,
		.pmem_write,
		.pmem_wdata
	);

endmodule : mp3_memory

/* dv/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
	parameter real period = 8.0
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end
endmodule : tb_clock

/* dv/pmem_model.sv */
`timescale 1ns/100ps
`include "lc3b_settings.svh"

module pmem_model #(
	parameter int min_delay = 1,
	parameter int max_delay = 6
) (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address,
	input lc3b_types::lc3b_c_block pmem_wdata,
	output lc3b_types::lc3b_c_block pmem_rdata,
	output logic pmem_resp
);
	import lc3b_types::*;

	localparam int block_bits = 16 - `LC3B_OFFSET_BITS;
	localparam int block_count = 1 << block_bits;

	lc3b_c_block mem [block_count];
	logic busy;
	int unsigned wait_left;

	// every byte depends on all address bits
	function automatic logic [7:0] fill_byte(input lc3b_word a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5a;
	endfunction

	function automatic lc3b_c_block peek_block(input lc3b_word address);
		return mem[address[15 -: block_bits]];
	endfunction

	initial begin
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		for (int b = 0; b < block_count; b++)
			for (int i = 0; i < `LC3B_BLOCK_BYTES; i++)
				mem[b][8*i +: 8] = fill_byte(lc3b_word'(b * `LC3B_BLOCK_BYTES + i));
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			wait_left <= 0;
			pmem_resp <= #1 1'b0;
		end else if (busy) begin
			if (wait_left == 1) begin
				busy <= 1'b0;
				pmem_resp <= #1 1'b1;
				pmem_rdata <= #1 mem[pmem_address[15 -: block_bits]];
				if (pmem_write)
					mem[pmem_address[15 -: block_bits]] <= pmem_wdata;
			end else begin
				wait_left <= wait_left - 1;
			end
		end else begin
			pmem_resp <= #1 1'b0;
			// the request is still up during the resp cycle
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				busy <= 1'b1;
				wait_left <= $urandom_range(max_delay, min_delay);
			end
		end
	end
endmodule : pmem_model

/* dv/tb_mp3_memory.sv */
`timescale 1ns/100ps
`include "lc3b_settings.svh"

module tb_mp3_memory;
	import lc3b_types::*;

	localparam int max_delay = 6;
	localparam int n_reads = 12;
	localparam int n_writes = 12;
	localparam int n_sets = 2;
	localparam int n_tags = 4;
	localparam int n_mixed = 16;
	localparam int n_accesses = 2 * n_reads + 2 * n_writes + n_sets * (n_tags + 1) + 3 * n_mixed;
	// worst miss pays pmem delay plus arbiter and resp cycles for both write-back and fill
	localparam int miss_cycles = 2 * (max_delay + 3) + 4;
	localparam int cycle_limit = 2 * n_accesses * miss_cycles + 100;

	logic clk;
	logic rst_n;
	lc3b_mem_req icache_req;
	lc3b_mem_req dcache_req;
	lc3b_word icache_rdata;
	lc3b_word dcache_rdata;
	logic icache_resp;
	logic dcache_resp;
	logic pmem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_c_block pmem_rdata;
	lc3b_c_block pmem_wdata;

	logic [7:0] model [1 << 16];
	lc3b_word addrs [$];
	int errors = 0;
	int failed_tests = 0;
	int cycles = 0;

	tb_clock #(.period(8.0)) clock_gen (.clk);
	mp3_memory mp3_memory_inst (.*);
	pmem_model #(.max_delay(max_delay)) pmem_model_inst (.*);

	function automatic logic [7:0] fill_byte(input lc3b_word a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5a;
	endfunction

	function automatic lc3b_word model_word(input lc3b_word a);
		return {model[{a[15:1], 1'b1}], model[{a[15:1], 1'b0}]};
	endfunction

	function automatic lc3b_c_block model_block(input lc3b_word a);
		lc3b_c_block b;
		lc3b_word base_addr;
		base_addr = a & ~lc3b_word'(`LC3B_BLOCK_BYTES - 1);
		for (int i = 0; i < `LC3B_BLOCK_BYTES; i++)
			b[8*i +: 8] = model[base_addr + i];
		return b;
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: FAIL with %0d errors", name, errors - errors_before);
			failed_tests++;
		end
	endtask

	// one d_cache access and the model update for a write
	task automatic d_access(input logic write, input lc3b_word a, input lc3b_word wdata,
			input lc3b_mem_wmask mask, output lc3b_word rdata, output int edges);
		edges = 0;
		@(posedge clk);
		#1;
		dcache_req = '{address: a, read: !write, write: write, wdata: wdata, byte_enable: mask};
		do begin
			@(posedge clk);
			edges++;
		end while (!dcache_resp);
		rdata = dcache_rdata;
		#1;
		dcache_req = '0;
		if (write && mask[0])
			model[{a[15:1], 1'b0}] = wdata[7:0];
		if (write && mask[1])
			model[{a[15:1], 1'b1}] = wdata[15:8];
	endtask

	task automatic i_read(input lc3b_word a, output lc3b_word rdata);
		@(posedge clk);
		#1;
		icache_req = '{address: a, read: 1'b1, write: 1'b0, wdata: '0, byte_enable: '0};
		do
			@(posedge clk);
		while (!icache_resp);
		rdata = icache_rdata;
		#1;
		icache_req = '0;
	endtask

	task automatic i_stream();
		lc3b_word a;
		lc3b_word got;
		for (int i = 0; i < n_mixed; i++) begin
			a = {1'b0, 14'($urandom), 1'b0};
			i_read(a, got);
			if (got !== model_word(a))
				report_mismatch("icache_rdata", model_word(a), got);
		end
	endtask

	task automatic d_stream();
		lc3b_word a;
		lc3b_word got;
		logic write;
		int edges;
		for (int i = 0; i < n_mixed; i++) begin
			a = {1'b1, 14'($urandom), 1'b0};
			write = 1'($urandom);
			d_access(write, a, 16'($urandom), 2'($urandom), got, edges);
			if (write)
				addrs.push_back(a);
			if (!write && got !== model_word(a))
				report_mismatch("dcache_rdata", model_word(a), got);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (pmem_read && pmem_write) begin
			$display("pmem_read and pmem_write were high together at %0t", $time);
			errors++;
		end
		if (cycles >= cycle_limit) begin
			$display("timeout, the run went past %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		lc3b_word a;
		lc3b_word got;
		lc3b_c_block blk;
		int edges;
		int base;
		rst_n = 1'b0;
		icache_req = '0;
		dcache_req = '0;
		void'($urandom(32'hde9d));
		for (int i = 0; i < (1 << 16); i++)
			model[i] = fill_byte(lc3b_word'(i));
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		base = errors;
		repeat (10) begin
			@(posedge clk);
			if ({pmem_read, pmem_write, icache_resp, dcache_resp} !== 4'b0)
				report_mismatch("pmem_read/pmem_write/icache_resp/dcache_resp", 0,
					{pmem_read, pmem_write, icache_resp, dcache_resp});
		end
		end_test("idle after reset", base);

		// cold miss followed by a hit on the same word
		base = errors;
		for (int i = 0; i < n_reads; i++) begin
			a = {1'b1, 14'($urandom), 1'b0};
			repeat (2) begin
				d_access(1'b0, a, '0, '0, got, edges);
				if (got !== model_word(a))
					report_mismatch("dcache_rdata", model_word(a), got);
			end
			if (edges != 2) begin
				$display("hit at %h answered after %0d cycles instead of 2", a, edges);
				errors++;
			end
		end
		end_test("read miss and hit", base);

		base = errors;
		addrs.delete();
		for (int i = 0; i < n_writes; i++) begin
			a = {1'b1, 14'($urandom), 1'b0};
			addrs.push_back(a);
			d_access(1'b1, a, 16'($urandom), 2'($urandom), got, edges);
		end
		foreach (addrs[i]) begin
			d_access(1'b0, addrs[i], '0, '0, got, edges);
			if (got !== model_word(addrs[i]))
				report_mismatch("dcache_rdata", model_word(addrs[i]), got);
		end
		end_test("masked writes", base);

		// each access takes a new tag on a shared index so the next one evicts it
		base = errors;
		addrs.delete();
		for (int s = 0; s < n_sets; s++) begin
			for (int t = 0; t <= n_tags; t++) begin
				a = {1'b1, 4'(t), 4'($urandom), 3'(2 * s + 1), 3'($urandom), 1'b0};
				if (t < n_tags) begin
					addrs.push_back(a);
					d_access(1'b1, a, 16'($urandom), 2'($urandom_range(3, 1)), got, edges);
				end else begin
					d_access(1'b0, a, '0, '0, got, edges);
				end
			end
		end
		foreach (addrs[i]) begin
			blk = pmem_model_inst.peek_block(addrs[i]);
			if (blk !== model_block(addrs[i]))
				report_mismatch("pmem block", model_block(addrs[i]), blk);
		end
		end_test("dirty evictions", base);

		base = errors;
		addrs.delete();
		fork
			i_stream();
			d_stream();
		join
		// mixed phase data writes read back after both streams end
		foreach (addrs[i]) begin
			d_access(1'b0, addrs[i], '0, '0, got, edges);
			if (got !== model_word(addrs[i]))
				report_mismatch("dcache_rdata", model_word(addrs[i]), got);
		end
		end_test("concurrent caches", base);

		$display("summary: 5 tests, %0d with errors, %0d errors in total", failed_tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end
endmodule : tb_mp3_memory

/* tb.f */
+incdir+common
common/lc3b_types.sv
cache/cache.sv
design/arbiter.sv
design/mp3_memory.sv
dv/tb_clock.sv
dv/pmem_model.sv
dv/tb_mp3_memory.sv

/* Bender.yml */
package:
  name: mp3_memory

export_include_dirs:
  - common

sources:
  - files:
      - common/lc3b_types.sv
      - cache/cache.sv
      - design/arbiter.sv
      - design/mp3_memory.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/pmem_model.sv
      - dv/tb_mp3_memory.sv
